/* include/procyon_consts.svh */
`ifndef PROCYON_CONSTS_SVH
`define PROCYON_CONSTS_SVH

// Datapath widths
`define PCYN_DATA_WIDTH 32
`define PCYN_ADDR_WIDTH 32

// Structure depths, powers of two
`define PCYN_REGMAP_DEPTH 32
`define PCYN_INSN_FIFO_DEPTH 8
`define PCYN_ROB_DEPTH 8
`define PCYN_RS_DEPTH 4

// RV32I major opcodes
`define PCYN_OPCODE_OP 7'b0110011
`define PCYN_OPCODE_OPIMM 7'b0010011
`define PCYN_OPCODE_LUI 7'b0110111

`endif

/* design/procyon_pkg.sv */
`default_nettype none

`include "procyon_consts.svh"

package procyon_pkg;

    typedef logic [`PCYN_DATA_WIDTH-1:0] data_t;
    typedef logic [`PCYN_ADDR_WIDTH-1:0] addr_t;
    typedef logic [$clog2(`PCYN_REGMAP_DEPTH)-1:0] regidx_t;
    typedef logic [$clog2(`PCYN_ROB_DEPTH)-1:0] rob_tag_t;

    // Operations understood by the IEU
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LUI
    } op_e;

    typedef enum logic {
        ROB_PENDING,
        ROB_COMPLETE
    } rob_state_e;

endpackage

`default_nettype wire

/* design/procyon_fu_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface procyon_fu_if;

    logic                  valid;
    procyon_pkg::op_e      op;
    procyon_pkg::data_t    src_a;
    procyon_pkg::data_t    src_b;
    procyon_pkg::rob_tag_t tag;
    logic                  stall;

    modport rs (output valid, output op, output src_a, output src_b, output tag,
                input stall);

    modport ieu (input valid, input op, input src_a, input src_b, input tag,
                 output stall);

endinterface

`default_nettype wire

/* design/procyon_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_consts.svh"

module procyon_fetch (
    input  logic               clk,
    input  logic               i_arst_n,
    input  procyon_pkg::data_t i_ic_insn,
    input  logic               i_ic_valid,
    output procyon_pkg::addr_t o_ic_pc,
    output logic               o_ic_en,
    input  logic               i_dispatch_stall,
    output logic               o_dispatch_valid,
    output procyon_pkg::addr_t o_dispatch_pc,
    output procyon_pkg::data_t o_dispatch_insn
);

    localparam int DEPTH = `PCYN_INSN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    procyon_pkg::addr_t fifo_pc [0:DEPTH-1];
    procyon_pkg::data_t fifo_insn [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] fifo_count;
    logic fifo_push;
    logic fifo_pop;

    assign o_ic_en = fifo_count != (PTR_W+1)'(DEPTH);
    assign fifo_push = o_ic_en && i_ic_valid;
    assign fifo_pop = o_dispatch_valid && !i_dispatch_stall;

    assign o_dispatch_valid = fifo_count != '0;
    assign o_dispatch_pc = fifo_pc[rd_ptr];
    assign o_dispatch_insn = fifo_insn[rd_ptr];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ic_pc <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end else begin
            // PC only moves on an accepted word
            if (fifo_push) begin
                o_ic_pc <= o_ic_pc + procyon_pkg::addr_t'(4);
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) rd_ptr <= rd_ptr + 1'b1;
            fifo_count <= fifo_count + (PTR_W+1)'(fifo_push) - (PTR_W+1)'(fifo_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_push) begin
            fifo_pc[wr_ptr] <= o_ic_pc;
            fifo_insn[wr_ptr] <= i_ic_insn;
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        fifo_count <= (PTR_W+1)'(DEPTH) && wr_ptr - rd_ptr == fifo_count[PTR_W-1:0]);

endmodule

`default_nettype wire

/* design/procyon_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_consts.svh"

module procyon_dispatch (
    input  logic                 i_dispatch_valid,
    input  procyon_pkg::addr_t   i_dispatch_pc,
    input  procyon_pkg::data_t   i_dispatch_insn,
    output logic                 o_dispatch_stall,
    input  logic                 i_rob_stall,
    input  logic                 i_rs_stall,
    output procyon_pkg::regidx_t o_lookup_rsrc [0:1],
    output procyon_pkg::regidx_t o_rename_rdest,
    output logic                 o_rob_reserve_en,
    output logic                 o_lookup_rdy_ovrd [0:1],
    output procyon_pkg::data_t   o_imm,
    output logic                 o_rs_reserve_en,
    output procyon_pkg::op_e     o_rs_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic sub_sra;
    procyon_pkg::regidx_t rd;
    procyon_pkg::regidx_t rs1;
    procyon_pkg::regidx_t rs2;
    procyon_pkg::data_t imm_i;
    procyon_pkg::data_t imm_u;
    procyon_pkg::op_e alu_op;

    assign opcode = i_dispatch_insn[6:0];
    assign rd = i_dispatch_insn[11:7];
    assign funct3 = i_dispatch_insn[14:12];
    assign rs1 = i_dispatch_insn[19:15];
    assign rs2 = i_dispatch_insn[24:20];
    assign imm_i = {{20{i_dispatch_insn[31]}}, i_dispatch_insn[31:20]};
    assign imm_u = {i_dispatch_insn[31:12], 12'b0};

    // Bit 30 picks SUB only for register forms, SRA/SRAI for both
    assign sub_sra = i_dispatch_insn[30] && (opcode == `PCYN_OPCODE_OP || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000: alu_op = sub_sra ? procyon_pkg::OP_SUB : procyon_pkg::OP_ADD;
            3'b001: alu_op = procyon_pkg::OP_SLL;
            3'b010: alu_op = procyon_pkg::OP_SLT;
            3'b011: alu_op = procyon_pkg::OP_SLTU;
            3'b100: alu_op = procyon_pkg::OP_XOR;
            3'b101: alu_op = sub_sra ? procyon_pkg::OP_SRA : procyon_pkg::OP_SRL;
            3'b110: alu_op = procyon_pkg::OP_OR;
            default: alu_op = procyon_pkg::OP_AND;
        endcase
    end

    // Override on src 0 yields zero, on src 1 yields the immediate
    always_comb begin
        o_rs_op = alu_op;
        o_rename_rdest = rd;
        o_lookup_rsrc[0] = rs1;
        o_lookup_rsrc[1] = rs2;
        o_lookup_rdy_ovrd[0] = rs1 == '0;
        o_lookup_rdy_ovrd[1] = rs2 == '0;
        o_imm = '0;
        case (opcode)
            `PCYN_OPCODE_OP: ;
            `PCYN_OPCODE_OPIMM: begin
                o_lookup_rdy_ovrd[1] = 1'b1;
                o_imm = imm_i;
            end
            `PCYN_OPCODE_LUI: begin
                o_rs_op = procyon_pkg::OP_LUI;
                o_lookup_rdy_ovrd[0] = 1'b1;
                o_lookup_rdy_ovrd[1] = 1'b1;
                o_imm = imm_u;
            end
            default: begin
                // Unknown encodings become ADDI x0, x0, 0
                o_rs_op = procyon_pkg::OP_ADD;
                o_rename_rdest = '0;
                o_lookup_rdy_ovrd[0] = 1'b1;
                o_lookup_rdy_ovrd[1] = 1'b1;
            end
        endcase
    end

    assign o_dispatch_stall = i_rob_stall || i_rs_stall;
    assign o_rob_reserve_en = i_dispatch_valid && !o_dispatch_stall;
    assign o_rs_reserve_en = o_rob_reserve_en;

    always_comb begin
        if (i_dispatch_valid) assert (i_dispatch_pc[1:0] == 2'b00);
    end

endmodule

`default_nettype wire

/* design/procyon_regmap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_consts.svh"

module procyon_regmap (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  procyon_pkg::regidx_t  i_lookup_rsrc [0:1],
    output logic                  o_lookup_rdy [0:1],
    output procyon_pkg::rob_tag_t o_lookup_tag [0:1],
    output procyon_pkg::data_t    o_lookup_data [0:1],
    input  logic                  i_rename_en,
    input  procyon_pkg::regidx_t  i_rename_rdest,
    input  procyon_pkg::rob_tag_t i_rename_tag,
    input  logic                  i_retire_en,
    input  procyon_pkg::regidx_t  i_retire_rdest,
    input  procyon_pkg::rob_tag_t i_retire_tag,
    input  procyon_pkg::data_t    i_retire_data
);

    localparam int DEPTH = `PCYN_REGMAP_DEPTH;

    procyon_pkg::data_t regmap_data [0:DEPTH-1];
    logic regmap_rdy [0:DEPTH-1];
    procyon_pkg::rob_tag_t regmap_tag [0:DEPTH-1];
    logic rename_valid;
    logic retire_valid;

    // x0 is never renamed or written
    assign rename_valid = i_rename_en && i_rename_rdest != '0;
    assign retire_valid = i_retire_en && i_retire_rdest != '0;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_lookup_rdy[s] = regmap_rdy[i_lookup_rsrc[s]];
            o_lookup_tag[s] = regmap_tag[i_lookup_rsrc[s]];
            o_lookup_data[s] = regmap_data[i_lookup_rsrc[s]];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regmap_data[i] <= '0;
                regmap_rdy[i] <= 1'b1;
            end
        end else begin
            if (retire_valid) begin
                regmap_data[i_retire_rdest] <= i_retire_data;
                // A newer rename keeps the register waiting
                if (regmap_tag[i_retire_rdest] == i_retire_tag) regmap_rdy[i_retire_rdest] <= 1'b1;
            end
            if (rename_valid) regmap_rdy[i_rename_rdest] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rename_valid) regmap_tag[i_rename_rdest] <= i_rename_tag;
    end

endmodule

`default_nettype wire

/* design/procyon_rob.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_consts.svh"

module procyon_rob #(
    parameter int OPTN_ROB_DEPTH = `PCYN_ROB_DEPTH
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_reserve_en,
    input  procyon_pkg::regidx_t  i_reserve_rdest,
    output procyon_pkg::rob_tag_t o_reserve_tag,
    output logic                  o_rob_stall,
    input  logic                  i_cdb_en,
    input  procyon_pkg::rob_tag_t i_cdb_tag,
    input  procyon_pkg::data_t    i_cdb_data,
    input  logic                  i_lookup_rdy_ovrd [0:1],
    input  procyon_pkg::data_t    i_imm,
    input  logic                  i_lookup_rdy [0:1],
    input  procyon_pkg::rob_tag_t i_lookup_tag [0:1],
    input  procyon_pkg::data_t    i_lookup_data [0:1],
    output logic                  o_src_rdy [0:1],
    output procyon_pkg::rob_tag_t o_src_tag [0:1],
    output procyon_pkg::data_t    o_src_data [0:1],
    output logic                  o_retire_en,
    output procyon_pkg::regidx_t  o_retire_rdest,
    output procyon_pkg::rob_tag_t o_retire_tag,
    output procyon_pkg::data_t    o_retire_data
);

    localparam int CNT_W = $clog2(OPTN_ROB_DEPTH) + 1;

    procyon_pkg::rob_state_e rob_state [0:OPTN_ROB_DEPTH-1];
    procyon_pkg::regidx_t rob_rdest [0:OPTN_ROB_DEPTH-1];
    procyon_pkg::data_t rob_data [0:OPTN_ROB_DEPTH-1];
    procyon_pkg::rob_tag_t rob_head;
    procyon_pkg::rob_tag_t rob_tail;
    logic [CNT_W-1:0] rob_count;

    assign o_rob_stall = rob_count == CNT_W'(OPTN_ROB_DEPTH);
    assign o_reserve_tag = rob_tail;

    assign o_retire_en = rob_count != '0 && rob_state[rob_head] == procyon_pkg::ROB_COMPLETE;
    assign o_retire_rdest = rob_rdest[rob_head];
    assign o_retire_tag = rob_head;
    assign o_retire_data = rob_data[rob_head];

    // Source resolution in priority order
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            o_src_tag[s] = i_lookup_tag[s];
            o_src_rdy[s] = 1'b1;
            if (i_lookup_rdy_ovrd[s]) begin
                o_src_data[s] = (s == 1) ? i_imm : '0;
            end else if (i_lookup_rdy[s]) begin
                o_src_data[s] = i_lookup_data[s];
            end else if (rob_state[i_lookup_tag[s]] == procyon_pkg::ROB_COMPLETE) begin
                o_src_data[s] = rob_data[i_lookup_tag[s]];
            end else if (i_cdb_en && i_cdb_tag == i_lookup_tag[s]) begin
                // Result on the bus this cycle would miss the RS wakeup
                o_src_data[s] = i_cdb_data;
            end else begin
                o_src_rdy[s] = 1'b0;
                o_src_data[s] = i_lookup_data[s];
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rob_head <= '0;
            rob_tail <= '0;
            rob_count <= '0;
            for (int i = 0; i < OPTN_ROB_DEPTH; i++) rob_state[i] <= procyon_pkg::ROB_PENDING;
        end else begin
            if (i_reserve_en) begin
                rob_state[rob_tail] <= procyon_pkg::ROB_PENDING;
                rob_tail <= rob_tail + 1'b1;
            end
            if (i_cdb_en) rob_state[i_cdb_tag] <= procyon_pkg::ROB_COMPLETE;
            if (o_retire_en) rob_head <= rob_head + 1'b1;
            rob_count <= rob_count + CNT_W'(i_reserve_en) - CNT_W'(o_retire_en);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reserve_en) rob_rdest[rob_tail] <= i_reserve_rdest;
        if (i_cdb_en) rob_data[i_cdb_tag] <= i_cdb_data;
    end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        i_cdb_en |-> rob_state[i_cdb_tag] == procyon_pkg::ROB_PENDING);

    assert property (@(posedge clk) disable iff (!i_arst_n)
        i_reserve_en |-> !o_rob_stall);

endmodule

`default_nettype wire

/* design/procyon_rs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "procyon_consts.svh"

module procyon_rs #(
    parameter int OPTN_RS_DEPTH = `PCYN_RS_DEPTH
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_reserve_en,
    input  procyon_pkg::op_e      i_op,
    input  procyon_pkg::rob_tag_t i_dst_tag,
    input  logic                  i_src_rdy [0:1],
    input  procyon_pkg::rob_tag_t i_src_tag [0:1],
    input  procyon_pkg::data_t    i_src_data [0:1],
    input  logic                  i_cdb_en,
    input  procyon_pkg::rob_tag_t i_cdb_tag,
    input  procyon_pkg::data_t    i_cdb_data,
    output logic                  o_rs_stall,
    procyon_fu_if.rs              fu
);

    localparam int IDX_W = $clog2(OPTN_RS_DEPTH);

    logic rs_valid [0:OPTN_RS_DEPTH-1];
    logic [IDX_W-1:0] rs_age [0:OPTN_RS_DEPTH-1];
    procyon_pkg::op_e rs_op [0:OPTN_RS_DEPTH-1];
    procyon_pkg::rob_tag_t rs_dst_tag [0:OPTN_RS_DEPTH-1];
    logic rs_src_rdy [0:OPTN_RS_DEPTH-1][0:1];
    procyon_pkg::rob_tag_t rs_src_tag [0:OPTN_RS_DEPTH-1][0:1];
    procyon_pkg::data_t rs_src_data [0:OPTN_RS_DEPTH-1][0:1];
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] issue_idx;
    logic [IDX_W-1:0] issue_age;
    logic issue_found;
    logic issue_en;

    always_comb begin
        o_rs_stall = 1'b1;
        free_idx = '0;
        for (int i = OPTN_RS_DEPTH - 1; i >= 0; i--) begin
            if (!rs_valid[i]) begin
                o_rs_stall = 1'b0;
                free_idx = IDX_W'(i);
            end
        end
        // Age counts later reservations, so the largest is the oldest
        issue_found = 1'b0;
        issue_idx = '0;
        issue_age = '0;
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            if (rs_valid[i] && rs_src_rdy[i][0] && rs_src_rdy[i][1] &&
                (!issue_found || rs_age[i] > issue_age)) begin
                issue_found = 1'b1;
                issue_idx = IDX_W'(i);
                issue_age = rs_age[i];
            end
        end
    end

    assign issue_en = issue_found && !fu.stall;
    assign fu.valid = issue_found;
    assign fu.op = rs_op[issue_idx];
    assign fu.src_a = rs_src_data[issue_idx][0];
    assign fu.src_b = rs_src_data[issue_idx][1];
    assign fu.tag = rs_dst_tag[issue_idx];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
                rs_valid[i] <= 1'b0;
                rs_age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
                if (i_reserve_en && free_idx == IDX_W'(i)) begin
                    rs_valid[i] <= 1'b1;
                    rs_age[i] <= '0;
                end else begin
                    if (i_reserve_en) rs_age[i] <= rs_age[i] + 1'b1;
                    if (issue_en && issue_idx == IDX_W'(i)) rs_valid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (i_reserve_en && free_idx == IDX_W'(i)) begin
                    rs_src_rdy[i][s] <= i_src_rdy[s];
                    rs_src_tag[i][s] <= i_src_tag[s];
                    rs_src_data[i][s] <= i_src_data[s];
                end else if (!rs_src_rdy[i][s] && i_cdb_en && rs_src_tag[i][s] == i_cdb_tag) begin
                    rs_src_rdy[i][s] <= 1'b1;
                    rs_src_data[i][s] <= i_cdb_data;
                end
            end
            if (i_reserve_en && free_idx == IDX_W'(i)) begin
                rs_op[i] <= i_op;
                rs_dst_tag[i] <= i_dst_tag;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        i_reserve_en |-> !o_rs_stall);

endmodule

`default_nettype wire

/* design/procyon_ieu.sv */
`timescale 1ns/1ps
`default_nettype none

module procyon_ieu (
    input  logic                  clk,
    input  logic                  i_arst_n,
    procyon_fu_if.ieu             fu,
    output logic                  o_cdb_en,
    output procyon_pkg::rob_tag_t o_cdb_tag,
    output procyon_pkg::data_t    o_cdb_data
);

    procyon_pkg::data_t alu_result;
    logic [4:0] shamt;

    // Single-cycle unit, never backs up
    assign fu.stall = 1'b0;
    assign shamt = fu.src_b[4:0];

    always_comb begin
        case (fu.op)
            procyon_pkg::OP_ADD: alu_result = fu.src_a + fu.src_b;
            procyon_pkg::OP_SUB: alu_result = fu.src_a - fu.src_b;
            procyon_pkg::OP_SLL: alu_result = fu.src_a << shamt;
            procyon_pkg::OP_SLT: alu_result = procyon_pkg::data_t'($signed(fu.src_a) < $signed(fu.src_b));
            procyon_pkg::OP_SLTU: alu_result = procyon_pkg::data_t'(fu.src_a < fu.src_b);
            procyon_pkg::OP_XOR: alu_result = fu.src_a ^ fu.src_b;
            procyon_pkg::OP_SRL: alu_result = fu.src_a >> shamt;
            procyon_pkg::OP_SRA: alu_result = procyon_pkg::data_t'($signed(fu.src_a) >>> shamt);
            procyon_pkg::OP_OR: alu_result = fu.src_a | fu.src_b;
            procyon_pkg::OP_AND: alu_result = fu.src_a & fu.src_b;
            procyon_pkg::OP_LUI: alu_result = fu.src_b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) o_cdb_en <= 1'b0;
        else o_cdb_en <= fu.valid && !fu.stall;
    end

    always_ff @(posedge clk) begin
        o_cdb_tag <= fu.tag;
        o_cdb_data <= alu_result;
    end

endmodule

`default_nettype wire

/* design/procyon.sv */
`timescale 1ns/1ps
`default_nettype none

module procyon (
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  procyon_pkg::data_t   i_ic_insn,
    input  logic                 i_ic_valid,
    output procyon_pkg::addr_t   o_ic_pc,
    output logic                 o_ic_en,
    output logic                 o_regmap_retire_en,
    output procyon_pkg::regidx_t o_regmap_retire_rdest,
    output procyon_pkg::data_t   o_regmap_retire_data
);

    logic dispatch_valid;
    logic dispatch_stall;
    procyon_pkg::addr_t dispatch_pc;
    procyon_pkg::data_t dispatch_insn;

    procyon_pkg::regidx_t lookup_rsrc [0:1];
    logic lookup_rdy [0:1];
    procyon_pkg::rob_tag_t lookup_tag [0:1];
    procyon_pkg::data_t lookup_data [0:1];
    logic lookup_rdy_ovrd [0:1];
    procyon_pkg::data_t dispatch_imm;
    procyon_pkg::regidx_t rename_rdest;

    logic rob_reserve_en;
    logic rob_stall;
    procyon_pkg::rob_tag_t rob_reserve_tag;
    logic rs_reserve_en;
    logic rs_stall;
    procyon_pkg::op_e rs_op;
    logic rs_src_rdy [0:1];
    procyon_pkg::rob_tag_t rs_src_tag [0:1];
    procyon_pkg::data_t rs_src_data [0:1];

    logic cdb_en;
    procyon_pkg::rob_tag_t cdb_tag;
    procyon_pkg::data_t cdb_data;

    logic retire_en;
    procyon_pkg::regidx_t retire_rdest;
    procyon_pkg::rob_tag_t retire_tag;
    procyon_pkg::data_t retire_data;

    procyon_fu_if fu_if ();

    // Retire bus doubles as the observation port
    assign o_regmap_retire_en = retire_en;
    assign o_regmap_retire_rdest = retire_rdest;
    assign o_regmap_retire_data = retire_data;

    procyon_fetch procyon_fetch_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .i_dispatch_stall(dispatch_stall),
        .o_dispatch_valid(dispatch_valid),
        .o_dispatch_pc(dispatch_pc),
        .o_dispatch_insn(dispatch_insn)
    );

    procyon_dispatch procyon_dispatch_inst (
        .i_dispatch_valid(dispatch_valid),
        .i_dispatch_pc(dispatch_pc),
        .i_dispatch_insn(dispatch_insn),
        .o_dispatch_stall(dispatch_stall),
        .i_rob_stall(rob_stall),
        .i_rs_stall(rs_stall),
        .o_lookup_rsrc(lookup_rsrc),
        .o_rename_rdest(rename_rdest),
        .o_rob_reserve_en(rob_reserve_en),
        .o_lookup_rdy_ovrd(lookup_rdy_ovrd),
        .o_imm(dispatch_imm),
        .o_rs_reserve_en(rs_reserve_en),
        .o_rs_op(rs_op)
    );

    procyon_regmap procyon_regmap_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_lookup_rsrc(lookup_rsrc),
        .o_lookup_rdy(lookup_rdy),
        .o_lookup_tag(lookup_tag),
        .o_lookup_data(lookup_data),
        .i_rename_en(rob_reserve_en),
        .i_rename_rdest(rename_rdest),
        .i_rename_tag(rob_reserve_tag),
        .i_retire_en(retire_en),
        .i_retire_rdest(retire_rdest),
        .i_retire_tag(retire_tag),
        .i_retire_data(retire_data)
    );

    procyon_rob procyon_rob_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_reserve_en(rob_reserve_en),
        .i_reserve_rdest(rename_rdest),
        .o_reserve_tag(rob_reserve_tag),
        .o_rob_stall(rob_stall),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .i_lookup_rdy_ovrd(lookup_rdy_ovrd),
        .i_imm(dispatch_imm),
        .i_lookup_rdy(lookup_rdy),
        .i_lookup_tag(lookup_tag),
        .i_lookup_data(lookup_data),
        .o_src_rdy(rs_src_rdy),
        .o_src_tag(rs_src_tag),
        .o_src_data(rs_src_data),
        .o_retire_en(retire_en),
        .o_retire_rdest(retire_rdest),
        .o_retire_tag(retire_tag),
        .o_retire_data(retire_data)
    );

    procyon_rs procyon_rs_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_reserve_en(rs_reserve_en),
        .i_op(rs_op),
        .i_dst_tag(rob_reserve_tag),
        .i_src_rdy(rs_src_rdy),
        .i_src_tag(rs_src_tag),
        .i_src_data(rs_src_data),
        .i_cdb_en(cdb_en),
        .i_cdb_tag(cdb_tag),
        .i_cdb_data(cdb_data),
        .o_rs_stall(rs_stall),
        .fu(fu_if.rs)
    );

    procyon_ieu procyon_ieu_inst (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .fu(fu_if.ieu),
        .o_cdb_en(cdb_en),
        .o_cdb_tag(cdb_tag),
        .o_cdb_data(cdb_data)
    );

endmodule

`default_nettype wire

/* testbench/procyon_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module procyon_tb;

    localparam int MAX_VECS = 64;
    localparam int TIMEOUT = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int N_INDEP = 8;
    localparam int N_CHAIN = 6;
    localparam int N_PRESS = 16;
    localparam logic [15:0] LFSR_SEED = 16'd39724;

    logic clk;
    logic i_arst_n;
    procyon_pkg::data_t i_ic_insn;
    logic i_ic_valid;
    procyon_pkg::addr_t o_ic_pc;
    logic o_ic_en;
    logic o_regmap_retire_en;
    procyon_pkg::regidx_t o_regmap_retire_rdest;
    procyon_pkg::data_t o_regmap_retire_data;

    // Instruction word, destination and value for each vector
    logic [31:0] vec_mem [0:3*MAX_VECS-1];
    int num_vecs;
    int errors;
    int tests_run;
    int tests_failed;
    int retire_count;
    int fetch_idx;
    logic hung;
    logic fetch_on;
    logic bubbles;
    logic [15:0] lfsr;
    procyon_pkg::addr_t accepted_pc [$];

    procyon uut (
        .clk(clk),
        .i_arst_n(i_arst_n),
        .i_ic_insn(i_ic_insn),
        .i_ic_valid(i_ic_valid),
        .o_ic_pc(o_ic_pc),
        .o_ic_en(o_ic_en),
        .o_regmap_retire_en(o_regmap_retire_en),
        .o_regmap_retire_rdest(o_regmap_retire_rdest),
        .o_regmap_retire_data(o_regmap_retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic check_data(input string name, input procyon_pkg::data_t exp,
                              input procyon_pkg::data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input procyon_pkg::regidx_t exp,
                             input procyon_pkg::regidx_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected x%0d, actual x%0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input procyon_pkg::addr_t exp,
                              input procyon_pkg::addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        i_arst_n = 1'b1;
    endtask

    // Next retire pulses must match vectors first .. first+count-1 in order
    task automatic run_retires(input string name, input int first, input int count);
        int start_errors;
        int waited;
        start_errors = errors;
        for (int k = first; k < first + count; k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!o_regmap_retire_en && waited < TIMEOUT);
            if (!o_regmap_retire_en) begin
                $display("test %s: no retire within %0d cycles for vector %0d", name, TIMEOUT, k);
                errors++;
                hung = 1'b1;
                return;
            end
            check_reg($sformatf("%s[%0d] rdest", name, k),
                      procyon_pkg::regidx_t'(vec_mem[3*k+1]), o_regmap_retire_rdest);
            check_data($sformatf("%s[%0d] data", name, k), vec_mem[3*k+2], o_regmap_retire_data);
        end
        report_test(name, start_errors);
    endtask

    task automatic run_bubbles();
        int start_errors;
        @(posedge clk);
        fetch_on = 1'b0;
        apply_reset();
        @(posedge clk);
        bubbles = 1'b1;
        fetch_on = 1'b1;
        run_retires("fetch_bubbles", 0, num_vecs);
        if (hung) return;
        start_errors = errors;
        if (accepted_pc.size() != num_vecs) begin
            $display("[ERROR] fetch_bubbles_pc: expected %0d accepted words, actual %0d",
                     num_vecs, accepted_pc.size());
            errors++;
        end
        for (int i = 0; i < accepted_pc.size(); i++) begin
            check_addr($sformatf("fetch_bubbles_pc[%0d]", i), procyon_pkg::addr_t'(4 * i),
                       accepted_pc[i]);
        end
        report_test("fetch_bubbles_pc", start_errors);
    endtask

    // Every retire pulse, counted apart from the ordered checks
    always @(negedge clk) begin
        if (i_arst_n && o_regmap_retire_en) retire_count++;
    end

    // Instruction memory model
    initial begin
        i_ic_valid = 1'b0;
        i_ic_insn = '0;
        lfsr = LFSR_SEED;
        forever begin
            @(negedge clk);
            fetch_idx = int'(o_ic_pc[31:2]);
            if (!fetch_on) begin
                i_ic_valid = 1'b0;
                lfsr = LFSR_SEED;
                accepted_pc.delete();
            end else if (o_ic_en && fetch_idx < num_vecs) begin
                if (bubbles) begin
                    lfsr = lfsr_next(lfsr);
                    i_ic_valid = lfsr[0];
                end else begin
                    i_ic_valid = 1'b1;
                end
                i_ic_insn = vec_mem[3*fetch_idx];
                if (i_ic_valid) accepted_pc.push_back(o_ic_pc);
            end else begin
                i_ic_valid = 1'b0;
            end
        end
    end

    initial begin
        int start_errors;
        i_arst_n = 1'b0;
        fetch_on = 1'b0;
        bubbles = 1'b0;
        hung = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        retire_count = 0;
        num_vecs = 0;
        // Unloaded slots read back as an out-of-range destination
        for (int i = 0; i < 3 * MAX_VECS; i++) begin
            vec_mem[i] = ~32'(i);
        end
        $readmemh("testbench/procyon_vectors.txt", vec_mem);
        while (num_vecs < MAX_VECS && vec_mem[3*num_vecs+1] < 32) num_vecs++;
        if (num_vecs != N_INDEP + N_CHAIN + N_PRESS) begin
            $display("vector file holds %0d vectors instead of %0d", num_vecs,
                     N_INDEP + N_CHAIN + N_PRESS);
            errors++;
            hung = 1'b1;
        end

        apply_reset();
        start_errors = errors;
        check_addr("reset pc", '0, o_ic_pc);
        check_flag("reset ic_en", 1'b1, o_ic_en);
        repeat (4) begin
            @(negedge clk);
            check_flag("reset retire_en", 1'b0, o_regmap_retire_en);
        end
        report_test("reset", start_errors);

        @(posedge clk);
        fetch_on = 1'b1;
        if (!hung) run_retires("alu_independent", 0, N_INDEP);
        if (!hung) run_retires("dependent_chain", N_INDEP, N_CHAIN);
        if (!hung) run_retires("back_pressure", N_INDEP + N_CHAIN, N_PRESS);
        if (!hung) begin
            start_errors = errors;
            repeat (20) begin
                @(negedge clk);
                check_flag("completion retire_en", 1'b0, o_regmap_retire_en);
            end
            if (retire_count != num_vecs) begin
                $display("[ERROR] completion: expected %0d retires, actual %0d",
                         num_vecs, retire_count);
                errors++;
            end
            report_test("completion", start_errors);
        end
        if (!hung) run_bubbles();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !hung) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/procyon_vectors.txt */
// Columns, all hex: instruction word, expected retire rd, expected retire value
// Registers start at 0; vectors 0-7 independent, 8-13 dependent, 14-29 one long chain
00500093 01 00000005 // addi x1, x0, 5
FFD00113 02 FFFFFFFD // addi x2, x0, -3
123451B7 03 12345000 // lui x3, 0x12345
7FF04213 04 000007FF // xori x4, x0, 0x7ff
F0006293 05 FFFFFF00 // ori x5, x0, -256
00103313 06 00000001 // sltiu x6, x0, 1
FFF02393 07 00000000 // slti x7, x0, -1
80000437 08 80000000 // lui x8, 0x80000
002084B3 09 00000002 // add x9, x1, x2
40348533 0A EDCBB002 // sub x10, x9, x3
40455593 0B FEDCBB00 // srai x11, x10, 4
0065D633 0C 7F6E5D80 // srl x12, x11, x6
00C5A6B3 0D 00000001 // slt x13, x11, x12
00D66733 0E 7F6E5D81 // or x14, x12, x13
005747B3 0F 8091A281 // xor x15, x14, x5
0FF7F793 0F 00000081 // andi x15, x15, 0xff
01879793 0F 81000000 // slli x15, x15, 24
4087D793 0F FF810000 // srai x15, x15, 8
0047D793 0F 0FF81000 // srli x15, x15, 4
FFF78793 0F 0FF80FFF // addi x15, x15, -1
FFF7B813 10 00000001 // sltiu x16, x15, -1
010798B3 11 1FF01FFE // sll x17, x15, x16
01183933 12 00000001 // sltu x18, x16, x17
412889B3 13 1FF01FFD // sub x19, x17, x18
FFF9CA13 14 E00FE002 // xori x20, x19, -1
404A5AB3 15 FFFFFFFF // sra x21, x20, x4
003AFB33 16 12345000 // and x22, x21, x3
0ABB6B93 17 123450AB // ori x23, x22, 0xab
017B8C33 18 2468A156 // add x24, x23, x23
018AACB3 19 00000001 // slt x25, x21, x24

/* flist.f */
+incdir+include
design/procyon_pkg.sv
design/procyon_fu_if.sv
design/procyon_fetch.sv
design/procyon_dispatch.sv
design/procyon_regmap.sv
design/procyon_rob.sv
design/procyon_rs.sv
design/procyon_ieu.sv
design/procyon.sv
testbench/procyon_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module procyon_tb \
    -f flist.f -o procyon_sim \
    && ./obj_dir/procyon_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
